/* segDisplay.f */
rtl/segDisplayPkg.sv
rtl/apbMapPkg.sv
rtl/segRegDecode.sv
rtl/digitScanner.sv
rtl/segmentEncoder.sv
rtl/segDisplayTop.sv
sim/clockGen.sv
sim/segDisplay_properties.sv
sim/segDisplayTb.sv

/* Makefile */
# Verilator build and run for the seven-segment APB display
# exit status of the run is the pass or fail result

VERILATOR ?= verilator
TOP       ?= segDisplayTb
LINT_TOP  ?= segDisplayTop
FILELIST  ?= segDisplay.f
OBJDIR    ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal
LINTFLAGS ?= --lint-only -Wall

SOURCES   := $(shell cat $(FILELIST))
RTL_SRCS  := $(filter rtl/%,$(SOURCES))

.PHONY: all build run lint clean

all: run

build: $(OBJDIR)/V$(TOP)

$(OBJDIR)/V$(TOP): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)

run: build
	./$(OBJDIR)/V$(TOP)

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(LINT_TOP) $(RTL_SRCS)

clean:
	rm -rf $(OBJDIR)

/* sim/segDisplayTb.sv */
/*
 * Table-driven testbench for segDisplayTop. Inputs change on the falling
 * edge, outputs are sampled there too. Random rows use a fixed seed, so
 * every run replays the same table.
 */
`timescale 1ns/10ps

module segDisplayTb;

    localparam int NumRows = 10;

    logic        clk;
    logic        rst_n;
    logic        psel;
    logic        penable;
    logic        pwrite;
    logic [apbMapPkg::AddrWidth-1:0]     paddr;
    logic [31:0] pwdata;
    logic [31:0] prdata;
    logic [segDisplayPkg::NumDigits-1:0] anodes;
    logic [segDisplayPkg::SegWidth-1:0]  segments;

    logic [31:0]                     rowDigits [NumRows];   // digits register per row
    logic [apbMapPkg::ScanWidth-1:0] rowScan   [NumRows];   // scan period per row
    logic [segDisplayPkg::SegWidth-1:0] rowExpSeg [NumRows][segDisplayPkg::NumDigits];

    int unsigned cycleCount = 0;
    int unsigned cycleLimit = 32'hFFFF_FFFF;    // real limit set once the table exists

    clockGen clocks (.clk(clk), .rst_n(rst_n));

    segDisplayTop uut (
        .clk, .rst_n, .psel, .penable, .pwrite, .paddr, .pwdata, .prdata,
        .anodes, .segments
    );

    bind segDisplayTop segDisplay_properties props (
        .clk(clk), .rst_n(rst_n), .enable(enable), .anodes(anodes), .segments(segments)
    );

    always @(posedge clk) begin
        cycleCount <= cycleCount + 1;
        if (cycleCount >= cycleLimit) begin
            $display("TEST FAILED");
            $fatal(1, "timeout, run still going after %0d cycles", cycleLimit);
        end
    end

    // active-low pattern a digit byte should show
    function automatic logic [segDisplayPkg::SegWidth-1:0] expectSeg(input logic [7:0] word);
        if (word[7]) begin
            return ~word[6:0];                  // raw view
        end
        else begin
            return ~segDisplayPkg::hexToSeg(word[3:0]);
        end
    endfunction

    task automatic checkValue(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            $display("ERR %0t %s got %h expected %h", $time, name, got, exp);
            $display("TEST FAILED");
            $fatal(1, "mismatch on %s", name);
        end
    endtask

    task automatic buildTable();
        int maxScan;
        int eff;
        void'($urandom(32'hc62bad01));
        rowDigits[0] = 32'h0302_0100;           // hex 0-3
        rowScan[0]   = 16'd1;
        rowDigits[1] = 32'h0706_0504;           // hex 4-7
        rowScan[1]   = 16'd2;
        rowDigits[2] = 32'hCFDB_86BF;           // raw copies of 0-3 patterns
        rowScan[2]   = 16'd0;                   // acts as 1
        rowDigits[3] = 32'h0B0A_0908;           // hex 8-B
        rowScan[3]   = 16'd3;
        rowDigits[4] = 32'hC981_FF80;           // raw all off, all on, odd bits
        rowScan[4]   = 16'd1;
        rowDigits[5] = 32'h7F6E_5D4C;           // hex C-F, reserved bits set
        rowScan[5]   = 16'd2;
        rowDigits[6] = 32'hE1B3_D5AA;
        rowScan[6]   = 16'd4;
        rowDigits[7] = $urandom & 32'h7F7F_7F7F; // random hex
        rowScan[7]   = 16'($urandom % 5);
        rowDigits[8] = $urandom | 32'h8080_8080; // random raw
        rowScan[8]   = 16'($urandom % 5);
        rowDigits[9] = $urandom | 32'h8080_8080;
        rowScan[9]   = 16'($urandom % 5);
        maxScan = 1;
        for (int r = 0; r < NumRows; r++) begin
            eff = (rowScan[r] == 0) ? 1 : int'(rowScan[r]);
            if (eff > maxScan) maxScan = eff;
            for (int d = 0; d < segDisplayPkg::NumDigits; d++) begin
                rowExpSeg[r][d] = expectSeg(
                    rowDigits[r][apbMapPkg::DigitBits*d +: apbMapPkg::DigitBits]);
            end
        end
        cycleLimit = 200 + NumRows * 4 * (maxScan + 2) * 3;
    endtask

    task automatic apbWrite(input logic [3:0] addr, input logic [31:0] data);
        @(negedge clk);
        psel    = 1'b1;                         // setup phase
        penable = 1'b0;
        pwrite  = 1'b1;
        paddr   = addr;
        pwdata  = data;
        @(negedge clk);
        penable = 1'b1;                         // access phase
        @(negedge clk);
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
    endtask

    task automatic apbRead(input logic [3:0] addr, output logic [31:0] data);
        @(negedge clk);
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = 1'b0;
        paddr   = addr;
        #1;
        checkValue("prdata in setup", prdata, 32'h0);
        @(negedge clk);
        penable = 1'b1;
        #1;
        data = prdata;                          // combinational, settled
        @(negedge clk);
        psel    = 1'b0;
        penable = 1'b0;
    endtask

    task automatic readCheck(input logic [3:0] addr, input logic [31:0] exp, input string name);
        logic [31:0] data;
        apbRead(addr, data);
        checkValue(name, data, exp);
    endtask

    task automatic checkBlank(input string when);
        checkValue({"anodes ", when}, 32'(anodes), 32'hF);
        checkValue({"segments ", when}, 32'(segments), 32'(segDisplayPkg::SegOff));
    endtask

    task automatic runRow(input int r);
        int period;
        logic [segDisplayPkg::NumDigits-1:0] expAnodes;
        period = (rowScan[r] == 0) ? 1 : int'(rowScan[r]);
        apbWrite(apbMapPkg::ScanAddr, {16'h0, rowScan[r]});
        apbWrite(apbMapPkg::DigitsAddr, rowDigits[r]);
        readCheck(apbMapPkg::ScanAddr, {16'h0, rowScan[r]}, "scanPeriod");
        readCheck(apbMapPkg::DigitsAddr, rowDigits[r], "digits");
        apbWrite(apbMapPkg::CtrlAddr, 32'h1);
        @(negedge clk);
        checkBlank("one edge after enable");
        @(negedge clk);                         // second edge, digit 0 lit
        for (int d = 0; d < segDisplayPkg::NumDigits; d++) begin
            expAnodes = ~(4'b0001 << d);
            for (int c = 0; c < period; c++) begin
                checkValue("anodes", 32'(anodes), 32'(expAnodes));
                checkValue("segments", 32'(segments), 32'(rowExpSeg[r][d]));
                @(negedge clk);
            end
        end
        checkValue("anodes after wrap", 32'(anodes), 32'hE);
        apbWrite(apbMapPkg::CtrlAddr, 32'h0);
        @(negedge clk);
        checkValue("anodes lit one edge after disable", 32'(anodes != 4'hF), 32'h1);
        @(negedge clk);
        checkBlank("after disable");
    endtask

    initial begin
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
        paddr   = '0;
        pwdata  = '0;
        buildTable();
        @(negedge clk);
        checkBlank("in reset");
        wait (rst_n === 1'b1);
        @(negedge clk);
        checkBlank("after reset");
        readCheck(apbMapPkg::CtrlAddr, 32'h0, "ctrl reset");
        readCheck(apbMapPkg::ScanAddr, 32'h1, "scanPeriod reset");
        readCheck(apbMapPkg::DigitsAddr, 32'h0, "digits reset");
        apbWrite(apbMapPkg::ScanAddr, 32'hFFFF_ABCD);   // upper half not stored
        readCheck(apbMapPkg::ScanAddr, 32'h0000_ABCD, "scanPeriod");
        apbWrite(apbMapPkg::DigitsAddr, 32'hDEAD_BEEF);
        readCheck(apbMapPkg::DigitsAddr, 32'hDEAD_BEEF, "digits");
        apbWrite(apbMapPkg::CtrlAddr, 32'h0000_0001);
        readCheck(apbMapPkg::CtrlAddr, 32'h1, "ctrl set");
        apbWrite(apbMapPkg::CtrlAddr, 32'hFFFF_FFFE);   // only bit 0 counts
        readCheck(apbMapPkg::CtrlAddr, 32'h0, "ctrl");
        apbWrite(4'hC, 32'h1234_5678);          // unmapped, dropped
        readCheck(4'hC, 32'h0, "unmapped 0xC");
        readCheck(4'h2, 32'h0, "unmapped 0x2");
        readCheck(apbMapPkg::ScanAddr, 32'h0000_ABCD, "scanPeriod after unmapped write");
        checkBlank("while disabled");
        for (int r = 0; r < NumRows; r++) begin
            runRow(r);
        end
        $display("TEST PASSED");
        $finish;
    end

endmodule

/* sim/segDisplay_properties.sv */
/*
 * Concurrent checks on the display outputs, bound into the top level
 * where the scanner anodes and the encoder segments meet.
 * enable is the control register bit, ahead of the scanner stage.
 */
`timescale 1ns/10ps

module segDisplay_properties (
    input logic                                 clk,
    input logic                                 rst_n,
    input logic                                 enable,
    input logic [segDisplayPkg::NumDigits-1:0]  anodes,
    input logic [segDisplayPkg::SegWidth-1:0]   segments
);

    // at most one digit lit
    anodeShape: assert property (@(posedge clk) disable iff (!rst_n)
        ($onehot(~anodes) || (anodes == '1)))
        else $error("anodes neither one-hot-low nor all high: %b", anodes);

    // dark digits carry a dark pattern
    blankSegments: assert property (@(posedge clk) disable iff (!rst_n)
        (anodes == '1) |-> (segments == segDisplayPkg::SegOff))
        else $error("segments %b while all anodes are off", segments);

    // enable cleared at edge W, anodes dark from W+2
    disableBlanks: assert property (@(posedge clk) disable iff (!rst_n)
        $fell(enable) |-> ##2 (anodes == '1))
        else $error("anodes %b still lit two cycles after disable", anodes);

endmodule

/* sim/clockGen.sv */
/*
 * Testbench clock, 10 ns period, and active-low reset held for two
 * rising edges, released on a falling edge.
 */
`timescale 1ns/10ps

module clockGen (
    output logic clk,
    output logic rst_n
);

    localparam int HalfPeriod = 5;              // ns

    initial begin
        clk = 1'b0;
        forever #HalfPeriod clk = ~clk;
    end

    initial begin
        rst_n = 1'b0;
        repeat (2) @(posedge clk);              // two cycles in reset
        @(negedge clk);
        rst_n = 1'b1;
    end

endmodule

/* rtl/segDisplayTop.sv */
/*
 * Four-digit common-anode seven-segment controller on APB.
 * Anodes and segments are active low and registered.
 */
`timescale 1ns/10ps

module segDisplayTop (
    input  logic                                 clk,
    input  logic                                 rst_n,
    input  logic                                 psel,
    input  logic                                 penable,
    input  logic                                 pwrite,
    input  logic [apbMapPkg::AddrWidth-1:0]      paddr,
    input  logic [31:0]                          pwdata,
    output logic [31:0]                          prdata,
    output logic [segDisplayPkg::NumDigits-1:0]  anodes,
    output logic [segDisplayPkg::SegWidth-1:0]   segments
);

    logic                               enable;     // control register bit
    logic [apbMapPkg::ScanWidth-1:0]    scanPeriod; // clocks per digit
    logic [31:0]                        digits;     // four digit bytes
    segDisplayPkg::digitWord_t          curDigit;   // byte for the lit digit
    logic                               encEnable;  // staged enable

    segRegDecode regs (
        .clk, .rst_n, .psel, .penable, .pwrite, .paddr, .pwdata, .prdata,
        .enable, .scanPeriod, .digits
    );

    digitScanner scanner (
        .clk, .rst_n, .enable, .scanPeriod, .digits,
        .curDigit, .encEnable, .anodes
    );

    segmentEncoder encoder (
        .clk, .rst_n, .encEnable, .curDigit, .segments
    );

endmodule

/* rtl/segmentEncoder.sv */
/*
 * Converts one digit word to active-low segments, registered.
 * Hex view decodes the low nibble, raw view passes bits 6:0 through.
 * Output is all dark while encEnable is low and after reset.
 */
`timescale 1ns/10ps

module segmentEncoder (
    input  logic                                 clk,
    input  logic                                 rst_n,
    input  logic                                 encEnable,
    input  segDisplayPkg::digitWord_t            curDigit,
    output logic [segDisplayPkg::SegWidth-1:0]   segments
);

    logic [segDisplayPkg::SegWidth-1:0] pattern; // active high, before the register
    logic                               isRaw;   // digit word in raw view

    //      -0-
    //     5   1
    //      -6-
    //     4   2
    //      -3-

    assign isRaw = curDigit.rawView.rawFlag;     // same bit in both views

    always_comb begin
        if (isRaw) begin
            pattern = curDigit.rawView.segments; // software picked the segments
        end
        else begin
            pattern = segDisplayPkg::hexToSeg(curDigit.hexView.hexValue);
        end
    end

    // common anode, so a lit segment is a low pin
    always_ff @(posedge clk, negedge rst_n) begin
        if (!rst_n) begin
            segments <= segDisplayPkg::SegOff;
        end
        else begin
            if (encEnable) begin
                segments <= ~pattern;
            end
            else begin
                segments <= segDisplayPkg::SegOff; // blank
            end
        end
    end

endmodule

/* rtl/digitScanner.sv */
/*
 * Time-multiplexes the digits: dwell counter, digit index, anode drive.
 * Register changes reach the outputs two edges after the APB write.
 * Anodes are active low; all high while disabled.
 */
`timescale 1ns/10ps

module digitScanner (
    input  logic                                  clk,
    input  logic                                  rst_n,
    input  logic                                  enable,
    input  logic [apbMapPkg::ScanWidth-1:0]       scanPeriod,
    input  logic [31:0]                           digits,
    output segDisplayPkg::digitWord_t             curDigit,
    output logic                                  encEnable,
    output logic [segDisplayPkg::NumDigits-1:0]   anodes
);

    localparam int IdxWidth = $clog2(segDisplayPkg::NumDigits);

    logic                                 enableQ;   // first stage of enable
    logic [IdxWidth-1:0]                  idx;       // digit being fed to encoder
    logic [apbMapPkg::ScanWidth-1:0]      dwell;     // clocks spent on idx
    logic [apbMapPkg::ScanWidth-1:0]      lastCount; // dwell value that ends a window
    segDisplayPkg::digitWord_t [segDisplayPkg::NumDigits-1:0] digitsQ; // staged digit bytes

    assign lastCount = (scanPeriod == '0) ? '0 : scanPeriod - 1'b1; // period 0 acts as 1

    always_ff @(posedge clk, negedge rst_n) begin
        if (!rst_n) begin
            enableQ <= 1'b0;
            idx     <= '0;
            dwell   <= '0;
            anodes  <= '1;                      // all digits dark
        end
        else begin
            enableQ <= enable;
            if (!enableQ) begin
                idx   <= '0;                    // restart at digit 0
                dwell <= '0;
            end
            else if (dwell >= lastCount) begin  // also catches a shrunk period
                dwell <= '0;
                idx   <= (idx == IdxWidth'(segDisplayPkg::NumDigits - 1)) ? '0 : idx + 1'b1;
            end
            else begin
                dwell <= dwell + 1'b1;
            end
            // second stage, lines up with the encoder register
            anodes <= enableQ ? ~(segDisplayPkg::NumDigits'(1) << idx) : '1;
        end
    end

    // digit bytes staged alongside enable
    always_ff @(posedge clk) begin
        digitsQ <= digits;
    end

    assign curDigit  = digitsQ[idx];
    assign encEnable = enableQ;

endmodule

/* rtl/segRegDecode.sv */
/*
 * APB slave with control, scan-period and digit registers.
 * Zero wait states, no pready or pslverr. prdata is combinational and
 * only valid in the access phase of a read; zero otherwise.
 */
`timescale 1ns/10ps

module segRegDecode (
    input  logic                             clk,
    input  logic                             rst_n,
    input  logic                             psel,
    input  logic                             penable,
    input  logic                             pwrite,
    input  logic [apbMapPkg::AddrWidth-1:0]  paddr,
    input  logic [31:0]                      pwdata,
    output logic [31:0]                      prdata,
    output logic                             enable,
    output logic [apbMapPkg::ScanWidth-1:0]  scanPeriod,
    output logic [31:0]                      digits
);

    logic writeEn;                              // access phase of a write
    logic readEn;                               // access phase of a read

    assign writeEn = psel && penable && pwrite;
    assign readEn  = psel && penable && !pwrite;

    // registers update at the edge ending the access phase
    always_ff @(posedge clk, negedge rst_n) begin
        if (!rst_n) begin
            enable     <= 1'b0;                 // display off
            scanPeriod <= apbMapPkg::ScanReset;
            digits     <= '0;                   // all digits show 0
        end
        else begin
            if (writeEn) begin
                case (paddr)
                    apbMapPkg::CtrlAddr: begin
                        enable <= pwdata[apbMapPkg::CtrlEnableBit];
                    end
                    apbMapPkg::ScanAddr: begin
                        scanPeriod <= pwdata[apbMapPkg::ScanWidth-1:0]; // 0 taken as 1 later
                    end
                    apbMapPkg::DigitsAddr: begin
                        digits <= pwdata;
                    end
                    default: begin
                        // unmapped, write dropped
                    end
                endcase
            end
        end
    end

    // read mux
    always_comb begin
        prdata = '0;                            // unmapped and idle read zero
        if (readEn) begin
            case (paddr)
                apbMapPkg::CtrlAddr: begin
                    prdata[apbMapPkg::CtrlEnableBit] = enable;
                end
                apbMapPkg::ScanAddr: begin
                    prdata[apbMapPkg::ScanWidth-1:0] = scanPeriod; // upper half zero
                end
                apbMapPkg::DigitsAddr: begin
                    prdata = digits;
                end
                default: begin
                    prdata = '0;
                end
            endcase
        end
    end

endmodule

/* rtl/apbMapPkg.sv */
/*
 * APB register map of the display block.
 * Full 32-bit registers only; no byte strobes, no aliasing of
 * unaligned addresses, so offsets 1-3, 5-7 and 9-F read as zero.
 */
package apbMapPkg;

    localparam int AddrWidth = 4;               // byte address, 16 bytes decoded

    localparam logic [AddrWidth-1:0] CtrlAddr   = 4'h0;  // bit 0 enable
    localparam logic [AddrWidth-1:0] ScanAddr   = 4'h4;  // clocks per digit
    localparam logic [AddrWidth-1:0] DigitsAddr = 4'h8;  // four digit bytes

    localparam int CtrlEnableBit = 0;           // in the control register
    localparam int ScanWidth     = 16;          // scan period field, bits 15:0

    // digit i lives in bits 8i+7 .. 8i of the digits register
    localparam int DigitBits = 8;

    localparam logic [ScanWidth-1:0] ScanReset = 16'd1;  // one clock per digit

endpackage

/* rtl/segDisplayPkg.sv */
/*
 * Display sizes, digit-word layout and segment encodings.
 * Segment numbering: 0 top, 1 upper right, 2 lower right, 3 bottom,
 * 4 lower left, 5 upper left, 6 middle. Hex table is active high.
 */
package segDisplayPkg;

    localparam int NumDigits = 4;               // digits on the board
    localparam int SegWidth  = 7;               // no decimal point

    localparam logic [SegWidth-1:0] SegOff = 7'b1111111; // common anode, all dark

    typedef struct packed {
        logic       rawFlag;                    // 0 here
        logic [2:0] reserved;                   // ignored
        logic [3:0] hexValue;                   // nibble to decode
    } hexView_t;

    typedef struct packed {
        logic                rawFlag;           // 1 here
        logic [SegWidth-1:0] segments;          // active high, passed straight
    } rawView_t;

    // one byte per digit, bit 7 picks the view
    typedef union packed {
        hexView_t hexView;
        rawView_t rawView;
    } digitWord_t;

    function automatic logic [SegWidth-1:0] hexToSeg(input logic [3:0] nibble);
        case (nibble)
            4'h0:    return 7'b0111111;
            4'h1:    return 7'b0000110;
            4'h2:    return 7'b1011011;
            4'h3:    return 7'b1001111;
            4'h4:    return 7'b1100110;
            4'h5:    return 7'b1101101;
            4'h6:    return 7'b1111101;
            4'h7:    return 7'b0000111;
            4'h8:    return 7'b1111111;
            4'h9:    return 7'b1101111;
            4'hA:    return 7'b1110111;
            4'hB:    return 7'b1111100;         // lower case b
            4'hC:    return 7'b1011000;         // lower case c
            4'hD:    return 7'b1011110;         // lower case d
            4'hE:    return 7'b1111001;
            4'hF:    return 7'b1110001;
            default: return 7'b0000000;         // unknown nibble, blank
        endcase
    endfunction

endpackage
